/* Makefile */
SRCS = vdp1Pkg.sv vdp1Regs.sv vdp1CmdFetch.sv vdp1CmdSeq.sv vdp1LineDraw.sv \
	vdp1PixelOut.sv vdp1Top.sv vdp1Tb.sv vdp1TbTests.svh

.PHONY: all run clean

all: obj_dir/Vvdp1Tb

obj_dir/Vvdp1Tb: $(SRCS) vdp1Top.f
	verilator --binary --timing --top-module vdp1Tb -f vdp1Top.f -o Vvdp1Tb

run: obj_dir/Vvdp1Tb
	-./obj_dir/Vvdp1Tb > sim.log 2>&1
	cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* vdp1CmdFetch.sv */
`timescale 1ns/10ps

module vdp1CmdFetch import vdp1Pkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        frameStart,
	input  logic        cmdRead,
	input  logic [17:0] cmdAddr,
	output logic [17:0] VRAM_A,
	output logic        VRAM_RD,
	input  logic [31:0] VRAM_Q,
	input  logic        VRAM_ARDY,
	input  logic        VRAM_DRDY,
	output cmdWord_u    ctrlLink,
	output logic [31:0] pmodColr,
	output cmdWord_u    vertA,
	output cmdWord_u    vertB,
	output cmdWord_u    vertC,
	output cmdWord_u    vertD,
	output logic        cmdDone
);
	logic       busy;
	logic       dataPend;
	logic       lastData;
	logic       drdyQ;
	logic [2:0] strobeCnt;
	logic [2:0] dataPos;
	logic       capture;

	assign capture = VRAM_DRDY & ~drdyQ & dataPend;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			VRAM_A <= '0;
			VRAM_RD <= 1'b0;
			busy <= 1'b0;
			dataPend <= 1'b0;
			lastData <= 1'b0;
			drdyQ <= 1'b0;
			strobeCnt <= '0;
			dataPos <= '0;
			cmdDone <= 1'b0;
		end else begin
			drdyQ <= VRAM_DRDY;
			cmdDone <= 1'b0;
			if (frameStart) begin
				busy <= 1'b0;
				VRAM_RD <= 1'b0;
				dataPend <= 1'b0;
				lastData <= 1'b0;
			end else begin
				if (cmdRead) begin
					VRAM_A <= cmdAddr;
					VRAM_RD <= 1'b1;
					busy <= 1'b1;
					strobeCnt <= '0;
				end else if (busy && VRAM_ARDY && !dataPend) begin
					// One 32-bit word per strobe, then wait for its data
					VRAM_A <= VRAM_A + 18'd2;
					dataPos <= strobeCnt;
					dataPend <= 1'b1;
					strobeCnt <= strobeCnt + 3'd1;
					if (strobeCnt == 3'd7) begin
						busy <= 1'b0;
						VRAM_RD <= 1'b0;
						lastData <= 1'b1;
					end
				end
				if (capture) begin
					dataPend <= 1'b0;
					cmdDone <= lastData;
					lastData <= 1'b0;
				end
			end
		end
	end

	// Words 2 and 7 hold sprite fields that lines never use
	always_ff @(posedge CLK) begin
		if (capture) begin
			case (dataPos)
				3'd0:    ctrlLink <= VRAM_Q;
				3'd1:    pmodColr <= VRAM_Q;
				3'd3:    vertA <= VRAM_Q;
				3'd4:    vertB <= VRAM_Q;
				3'd5:    vertC <= VRAM_Q;
				3'd6:    vertD <= VRAM_Q;
				default: ;
			endcase
		end
	end

endmodule

/* vdp1CmdSeq.sv */
`timescale 1ns/10ps

module vdp1CmdSeq import vdp1Pkg::*; (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               frameStart,
	input  cmdWord_u           ctrlLink,
	input  logic [31:0]        pmodColr,
	input  cmdWord_u           vertA,
	input  cmdWord_u           vertB,
	input  cmdWord_u           vertC,
	input  cmdWord_u           vertD,
	input  logic               cmdDone,
	output logic               cmdRead,
	output logic [17:0]        cmdAddr,
	output logic               lineStart,
	output cmdWord_u           lineA,
	output cmdWord_u           lineB,
	input  logic               lineDone,
	output logic               listEnd,
	output logic [15:0]        copr,
	output logic [COORD_W-1:0] localX,
	output logic [COORD_W-1:0] localY,
	output logic [COORD_W-1:0] sysClipX2,
	output logic [COORD_W-1:0] sysClipY2,
	output logic [COORD_W-1:0] userClipX1,
	output logic [COORD_W-1:0] userClipY1,
	output logic [COORD_W-1:0] userClipX2,
	output logic [COORD_W-1:0] userClipY2
);
	logic [3:0]  state;
	logic [1:0]  edgeIdx;
	logic [17:0] retAddr;
	logic [3:0]  comm;
	logic [1:0]  jp;
	logic        skip;
	logic        lastCmd;
	logic        userEmpty;

	assign comm = ctrlLink.cl.ctrl[3:0];
	assign jp = ctrlLink.cl.ctrl[CTRL_JP +: 2];
	assign skip = ctrlLink.cl.ctrl[CTRL_SKIP];
	assign lastCmd = ctrlLink.cl.ctrl[CTRL_END];
	// A clipped line can't reach an empty user window
	assign userEmpty = pmodColr[PMOD_CLIP] &
		((userClipX1 > userClipX2) | (userClipY1 > userClipY2));

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= SEQ_IDLE;
			edgeIdx <= '0;
			cmdAddr <= '0;
			retAddr <= '0;
			cmdRead <= 1'b0;
			lineStart <= 1'b0;
			listEnd <= 1'b0;
			copr <= '0;
			localX <= '0;
			localY <= '0;
			sysClipX2 <= SYS_CLIP_X_RESET;
			sysClipY2 <= SYS_CLIP_Y_RESET;
			userClipX1 <= '0;
			userClipY1 <= '0;
			userClipX2 <= '0;
			userClipY2 <= '0;
		end else begin
			cmdRead <= 1'b0;
			lineStart <= 1'b0;
			listEnd <= 1'b0;
			if (frameStart) begin
				cmdAddr <= '0;
				cmdRead <= 1'b1;
				state <= SEQ_READ;
			end else begin
				case (state)
					SEQ_READ: begin
						if (cmdDone) begin
							copr <= cmdAddr[17:2];
							state <= SEQ_EXEC;
						end
					end
					SEQ_EXEC: begin
						state <= SEQ_END;
						if (!skip && !lastCmd) begin
							case (comm)
								CMD_LINE, CMD_POLYLINE, CMD_POLYLINE_ALT: begin
									if (!userEmpty) begin
										edgeIdx <= '0;
										state <= SEQ_EDGE;
									end
								end
								CMD_USER_CLIP: begin
									userClipX1 <= vertA.xy.x[COORD_W-1:0];
									userClipY1 <= vertA.xy.y[COORD_W-1:0];
									userClipX2 <= vertC.xy.x[COORD_W-1:0];
									userClipY2 <= vertC.xy.y[COORD_W-1:0];
								end
								CMD_SYS_CLIP: begin
									sysClipX2 <= vertC.xy.x[COORD_W-1:0];
									sysClipY2 <= vertC.xy.y[COORD_W-1:0];
								end
								CMD_LOCAL: begin
									localX <= vertA.xy.x[COORD_W-1:0];
									localY <= vertA.xy.y[COORD_W-1:0];
								end
								default: ;
							endcase
						end
					end
					SEQ_EDGE: begin
						lineStart <= 1'b1;
						state <= SEQ_WAIT;
					end
					SEQ_WAIT: begin
						if (lineDone) begin
							if (comm == CMD_LINE || edgeIdx == 2'd3) begin
								state <= SEQ_END;
							end else begin
								edgeIdx <= edgeIdx + 2'd1;
								state <= SEQ_EDGE;
							end
						end
					end
					SEQ_END: begin
						case (jp)
							JP_NEXT: cmdAddr <= cmdAddr + CMD_STRIDE;
							JP_JUMP: cmdAddr <= {ctrlLink.cl.link, 2'b00};
							JP_CALL: begin
								cmdAddr <= {ctrlLink.cl.link, 2'b00};
								retAddr <= cmdAddr + CMD_STRIDE;
							end
							JP_RETURN: cmdAddr <= retAddr;
						endcase
						if (lastCmd) begin
							listEnd <= 1'b1;
							state <= SEQ_IDLE;
						end else begin
							cmdRead <= 1'b1;
							state <= SEQ_READ;
						end
					end
					default: state <= SEQ_IDLE;
				endcase
			end
		end
	end

	// Edge order A-B, B-C, C-D, D-A
	always_ff @(posedge CLK) begin
		if (state == SEQ_EDGE) begin
			case (edgeIdx)
				2'd0: begin
					lineA <= vertA;
					lineB <= vertB;
				end
				2'd1: begin
					lineA <= vertB;
					lineB <= vertC;
				end
				2'd2: begin
					lineA <= vertC;
					lineB <= vertD;
				end
				default: begin
					lineA <= vertD;
					lineB <= vertA;
				end
			endcase
		end
	end

endmodule

/* vdp1LineDraw.sv */
`timescale 1ns/10ps

module vdp1LineDraw import vdp1Pkg::*; (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               lineStart,
	input  cmdWord_u           lineA,
	input  cmdWord_u           lineB,
	output logic [COORD_W-1:0] pixX,
	output logic [COORD_W-1:0] pixY,
	output logic               pixValid,
	output logic               lineDone
);
	logic [COORD_W-1:0] ax;
	logic [COORD_W-1:0] ay;
	logic [COORD_W-1:0] bx;
	logic [COORD_W-1:0] by;
	logic [COORD_W:0]   diffX;
	logic [COORD_W:0]   diffY;
	logic [COORD_W-1:0] absX;
	logic [COORD_W-1:0] absY;
	logic               majX;
	logic [COORD_W-1:0] spanMaj;
	logic [COORD_W-1:0] spanMin;
	logic [COORD_W-1:0] endMaj;
	logic               dirX;
	logic               dirY;
	logic               xMajor;
	logic [COORD_W:0]   acc;
	logic [COORD_W:0]   accSum;
	logic               stepMin;
	logic               atEnd;
	logic [COORD_W-1:0] stepX;
	logic [COORD_W-1:0] stepY;

	assign ax = lineA.xy.x[COORD_W-1:0];
	assign ay = lineA.xy.y[COORD_W-1:0];
	assign bx = lineB.xy.x[COORD_W-1:0];
	assign by = lineB.xy.y[COORD_W-1:0];

	// One extra bit so opposite extremes don't wrap
	assign diffX = {bx[COORD_W-1], bx} - {ax[COORD_W-1], ax};
	assign diffY = {by[COORD_W-1], by} - {ay[COORD_W-1], ay};
	assign absX = diffX[COORD_W] ? ~diffX[COORD_W-1:0] + 1'b1 : diffX[COORD_W-1:0];
	assign absY = diffY[COORD_W] ? ~diffY[COORD_W-1:0] + 1'b1 : diffY[COORD_W-1:0];
	assign majX = absX >= absY;

	assign accSum = acc + {1'b0, spanMin};
	assign stepMin = accSum >= {1'b0, spanMaj};
	assign atEnd = xMajor ? (pixX == endMaj) : (pixY == endMaj);
	assign stepX = {{(COORD_W-1){dirX}}, 1'b1};
	assign stepY = {{(COORD_W-1){dirY}}, 1'b1};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pixValid <= 1'b0;
			lineDone <= 1'b0;
		end else begin
			lineDone <= 1'b0;
			if (lineStart) begin
				pixValid <= 1'b1;
			end else if (pixValid && atEnd) begin
				pixValid <= 1'b0;
				lineDone <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (lineStart) begin
			pixX <= ax;
			pixY <= ay;
			dirX <= diffX[COORD_W];
			dirY <= diffY[COORD_W];
			xMajor <= majX;
			spanMaj <= majX ? absX : absY;
			spanMin <= majX ? absY : absX;
			endMaj <= majX ? bx : by;
			acc <= '0;
		end else if (pixValid && !atEnd) begin
			acc <= stepMin ? accSum - {1'b0, spanMaj} : accSum;
			if (xMajor) begin
				pixX <= pixX + stepX;
				if (stepMin) begin
					pixY <= pixY + stepY;
				end
			end else begin
				pixY <= pixY + stepY;
				if (stepMin) begin
					pixX <= pixX + stepX;
				end
			end
		end
	end

endmodule

/* vdp1PixelOut.sv */
`timescale 1ns/10ps

module vdp1PixelOut import vdp1Pkg::*; (
	input  logic [COORD_W-1:0]   pixX,
	input  logic [COORD_W-1:0]   pixY,
	input  logic                 pixValid,
	input  logic [COORD_W-1:0]   localX,
	input  logic [COORD_W-1:0]   localY,
	input  logic [COORD_W-1:0]   sysClipX2,
	input  logic [COORD_W-1:0]   sysClipY2,
	input  logic [COORD_W-1:0]   userClipX1,
	input  logic [COORD_W-1:0]   userClipY1,
	input  logic [COORD_W-1:0]   userClipX2,
	input  logic [COORD_W-1:0]   userClipY2,
	input  logic [31:0]          pmodColr,
	output logic [FB_ADDR_W-1:0] FB_A,
	output logic [15:0]          FB_D,
	output logic                 FB_WE
);
	logic [COORD_W:0] posX;
	logic [COORD_W:0] posY;
	logic             inSys;
	logic             inUser;

	assign posX = {pixX[COORD_W-1], pixX} + {localX[COORD_W-1], localX};
	assign posY = {pixY[COORD_W-1], pixY} + {localY[COORD_W-1], localY};

	// Negative positions fail before the unsigned compares
	assign inSys = !posX[COORD_W] && !posY[COORD_W] &&
		posX[COORD_W-1:0] <= sysClipX2 && posY[COORD_W-1:0] <= sysClipY2;
	assign inUser = posX[COORD_W-1:0] >= userClipX1 && posX[COORD_W-1:0] <= userClipX2 &&
		posY[COORD_W-1:0] >= userClipY1 && posY[COORD_W-1:0] <= userClipY2;

	assign FB_A = {posY[7:0], posX[8:0]};
	assign FB_D = pmodColr[15:0];
	assign FB_WE = pixValid & inSys & (inUser | ~pmodColr[PMOD_CLIP]);

endmodule

/* vdp1Pkg.sv */
package vdp1Pkg;

	// Register byte offsets
	localparam logic [4:0] REG_PTMR = 5'h04;
	localparam logic [4:0] REG_EDSR = 5'h10;
	localparam logic [4:0] REG_LOPR = 5'h12;
	localparam logic [4:0] REG_COPR = 5'h14;

	// Command codes
	localparam logic [3:0] CMD_POLYLINE = 4'h5;
	localparam logic [3:0] CMD_LINE = 4'h6;
	localparam logic [3:0] CMD_POLYLINE_ALT = 4'h7;
	localparam logic [3:0] CMD_USER_CLIP = 4'h8;
	localparam logic [3:0] CMD_SYS_CLIP = 4'h9;
	localparam logic [3:0] CMD_LOCAL = 4'hA;

	// Jump modes
	localparam logic [1:0] JP_NEXT = 2'd0;
	localparam logic [1:0] JP_JUMP = 2'd1;
	localparam logic [1:0] JP_CALL = 2'd2;
	localparam logic [1:0] JP_RETURN = 2'd3;

	// One command table in 16-bit words
	localparam logic [17:0] CMD_STRIDE = 18'd16;

	localparam int COORD_W = 11;
	localparam logic [COORD_W-1:0] SYS_CLIP_X_RESET = 11'h13F;
	localparam logic [COORD_W-1:0] SYS_CLIP_Y_RESET = 11'h0FF;
	localparam int FB_ADDR_W = 17;

	// Bit positions in the control word and the mode/colour word
	localparam int CTRL_END = 15;
	localparam int CTRL_SKIP = 14;
	localparam int CTRL_JP = 12;
	localparam int PMOD_CLIP = 26;

	// Sequencer states
	localparam logic [3:0] SEQ_IDLE = 4'd0;
	localparam logic [3:0] SEQ_READ = 4'd1;
	localparam logic [3:0] SEQ_EXEC = 4'd2;
	localparam logic [3:0] SEQ_EDGE = 4'd3;
	localparam logic [3:0] SEQ_WAIT = 4'd4;
	localparam logic [3:0] SEQ_END = 4'd5;

	typedef union packed {
		struct packed {
			logic [15:0] ctrl;
			logic [15:0] link;
		} cl;
		struct packed {
			logic signed [15:0] x;
			logic signed [15:0] y;
		} xy;
	} cmdWord_u;

endpackage

/* vdp1Regs.sv */
`timescale 1ns/10ps

module vdp1Regs import vdp1Pkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic [15:0] DI,
	output logic [15:0] DO,
	input  logic        CS_N,
	input  logic        AD_N,
	input  logic        DTEN_N,
	input  logic [1:0]  WE_N,
	output logic        RDY_N,
	output logic        IRQ_N,
	input  logic        listEnd,
	input  logic [15:0] copr,
	output logic        frameStart
);
	logic [20:0] addr;
	logic [4:0]  regOff;
	logic        regSel;
	logic        startPend;
	logic        cef;
	logic        bef;
	logic [15:0] coprLast;
	logic [15:0] lopr;

	assign regSel = (addr[20:19] == 2'b10) & ~CS_N & ~AD_N & ~DTEN_N;
	assign regOff = {addr[4:1], 1'b0};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			addr <= '0;
			DO <= '0;
			startPend <= 1'b0;
			frameStart <= 1'b0;
		end else begin
			// Two address strobes build the 21-bit address
			if (!CS_N && AD_N && DTEN_N) begin
				addr <= {addr[4:0], DI};
			end
			startPend <= 1'b0;
			if (regSel && !(&WE_N)) begin
				if (regOff == REG_PTMR && DI[1:0] == 2'b01) begin
					startPend <= 1'b1;
				end
			end else if (regSel) begin
				case (regOff)
					REG_EDSR: DO <= {14'd0, cef, bef};
					REG_LOPR: DO <= lopr;
					REG_COPR: DO <= copr;
					default:  DO <= '0;
				endcase
			end
			frameStart <= startPend;
		end
	end

	// End status flags
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cef <= 1'b0;
			bef <= 1'b0;
		end else if (frameStart) begin
			cef <= 1'b0;
			bef <= cef;
		end else if (listEnd) begin
			cef <= 1'b1;
		end
	end

	// New table address means the old one becomes LOPR
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			coprLast <= '0;
			lopr <= '0;
		end else if (copr != coprLast) begin
			coprLast <= copr;
			lopr <= coprLast;
		end
	end

	assign RDY_N = ~regSel;
	assign IRQ_N = ~cef;

endmodule

/* vdp1TbTests.svh */
// Model state of the clip and local registers
int locX = 0;
int locY = 0;
int sysX2 = 'h13F;
int sysY2 = 'hFF;
int ucX1 = 0;
int ucY1 = 0;
int ucX2 = 0;
int ucY2 = 0;

function automatic logic [15:0] ctrlWord(input logic endBit, input logic skipBit,
	input logic [1:0] jump, input logic [3:0] code);
	return {endBit, skipBit, jump, 8'h00, code};
endfunction

task automatic clearAll();
	for (int i = 0; i < 1024; i++) begin
		vram[i] = '0;
	end
	for (int a = 0; a < FB_SIZE; a++) begin
		fbData[a] <= '0;
		fbCnt[a] <= '0;
		expData[a] = '0;
		expCnt[a] = '0;
	end
endtask

// Table idx sits at 16-bit address idx*16, link value idx*4
task automatic writeTable(input int idx, input logic [15:0] ctrl, input int link,
	input logic [31:0] pc, input int ax, input int ay, input int bx, input int by,
	input int cx, input int cy, input int dx, input int dy);
	int base;
	base = idx * 8;
	vram[base] = {ctrl, link[15:0]};
	vram[base + 1] = pc;
	vram[base + 3] = {ax[15:0], ay[15:0]};
	vram[base + 4] = {bx[15:0], by[15:0]};
	vram[base + 5] = {cx[15:0], cy[15:0]};
	vram[base + 6] = {dx[15:0], dy[15:0]};
endtask

task automatic putPixel(input int x, input int y, input logic [31:0] pc);
	int px;
	int py;
	int a;
	px = x + locX;
	py = y + locY;
	if (px >= 0 && py >= 0 && px <= sysX2 && py <= sysY2 && (!pc[PMOD_CLIP] ||
		(px >= ucX1 && px <= ucX2 && py >= ucY1 && py <= ucY2))) begin
		a = (py & 255) * 512 + (px & 511);
		expData[a] = pc[15:0];
		expCnt[a] = expCnt[a] + 8'd1;
	end
endtask

task automatic plotLine(input int ax, input int ay, input int bx, input int by,
	input logic [31:0] pc);
	int x;
	int y;
	int sx;
	int sy;
	int adx;
	int ady;
	int acc;
	logic xMaj;
	x = ax;
	y = ay;
	sx = (bx < ax) ? -1 : 1;
	sy = (by < ay) ? -1 : 1;
	adx = (bx < ax) ? ax - bx : bx - ax;
	ady = (by < ay) ? ay - by : by - ay;
	xMaj = adx >= ady;
	acc = 0;
	while (1) begin
		putPixel(x, y, pc);
		if (xMaj ? (x == bx) : (y == by)) break;
		if (xMaj) begin
			x += sx;
			acc += ady;
			if (acc >= adx) begin
				acc -= adx;
				y += sy;
			end
		end else begin
			y += sy;
			acc += adx;
			if (acc >= ady) begin
				acc -= ady;
				x += sx;
			end
		end
	end
endtask

task automatic busAccess(input logic [4:0] off, input logic wr, input logic [15:0] wdata,
	output logic [15:0] rdata);
	@(posedge CLK);
	CS_N <= 1'b0;
	AD_N <= 1'b1;
	DTEN_N <= 1'b1;
	DI <= 16'h0010;
	@(posedge CLK);
	DI <= {11'd0, off};
	@(posedge CLK);
	AD_N <= 1'b0;
	DTEN_N <= 1'b0;
	DI <= wdata;
	WE_N <= wr ? 2'b00 : 2'b11;
	@(posedge CLK);
	checkVal("bus RDY_N", 0, RDY_N);
	CS_N <= 1'b1;
	AD_N <= 1'b1;
	DTEN_N <= 1'b1;
	WE_N <= 2'b11;
	@(negedge CLK);
	rdata = DO;
endtask

task automatic waitIrq(input logic level);
	int n;
	n = 0;
	while (IRQ_N !== level) begin
		@(posedge CLK);
		n++;
		if (n > 1500) failRun("IRQ_N did not change level while waiting for the frame");
	end
endtask

task automatic runFrame();
	logic [15:0] unused;
	busAccess(REG_PTMR, 1'b1, 16'h0001, unused);
	waitIrq(1'b1);
	waitIrq(1'b0);
endtask

task automatic checkFrame(input string name);
	for (int a = 0; a < FB_SIZE; a++) begin
		if (fbCnt[a] !== expCnt[a] || (expCnt[a] != 0 && fbData[a] !== expData[a])) begin
			$display("Frame buffer address %h differs", a);
			checkVal({name, " write count"}, expCnt[a], fbCnt[a]);
			checkVal({name, " pixel"}, expData[a], fbData[a]);
		end
	end
endtask

task automatic testEndOfList();
	logic [15:0] rd;
	clearAll();
	writeTable(0, ctrlWord(1, 0, JP_NEXT, CMD_LINE), 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	// Interrupt is inactive until the first list ends
	checkVal("reset IRQ_N", 1, IRQ_N);
	runFrame();
	busAccess(REG_EDSR, 1'b0, 0, rd);
	checkVal("end EDSR first", 16'h0002, rd);
	checkVal("end IRQ_N", 0, IRQ_N);
	runFrame();
	busAccess(REG_EDSR, 1'b0, 0, rd);
	checkVal("end EDSR second", 16'h0003, rd);
	checkFrame("end");
endtask

task automatic testLines();
	clearAll();
	writeTable(0, ctrlWord(0, 0, JP_NEXT, CMD_LINE), 0, 32'h1111, 10, 20, 40, 20, 0, 0, 0, 0);
	writeTable(1, ctrlWord(0, 0, JP_NEXT, CMD_LINE), 0, 32'h2222, 50, 10, 50, 30, 0, 0, 0, 0);
	writeTable(2, ctrlWord(0, 0, JP_NEXT, CMD_LINE), 0, 32'h3333, 60, 10, 66, 40, 0, 0, 0, 0);
	writeTable(3, ctrlWord(0, 0, JP_NEXT, CMD_LINE), 0, 32'h4444, 100, 60, 80, 50, 0, 0, 0, 0);
	writeTable(4, ctrlWord(0, 0, JP_NEXT, CMD_LINE), 0, 32'h5555, 30, 90, 35, 70, 0, 0, 0, 0);
	writeTable(5, ctrlWord(1, 0, JP_NEXT, 4'h0), 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	plotLine(10, 20, 40, 20, 32'h1111);
	plotLine(50, 10, 50, 30, 32'h2222);
	plotLine(60, 10, 66, 40, 32'h3333);
	plotLine(100, 60, 80, 50, 32'h4444);
	plotLine(30, 90, 35, 70, 32'h5555);
	runFrame();
	checkFrame("lines");
endtask

task automatic testClipLocal();
	clearAll();
	writeTable(0, ctrlWord(0, 0, JP_NEXT, CMD_LOCAL), 0, 0, 10, 5, 0, 0, 0, 0, 0, 0);
	writeTable(1, ctrlWord(0, 0, JP_NEXT, CMD_SYS_CLIP), 0, 0, 0, 0, 0, 0, 60, 40, 0, 0);
	writeTable(2, ctrlWord(0, 0, JP_NEXT, CMD_USER_CLIP), 0, 0, 20, 10, 0, 0, 40, 30, 0, 0);
	writeTable(3, ctrlWord(0, 0, JP_NEXT, CMD_LINE), 0, 32'h0400_6161,
		-20, 0, 70, 45, 0, 0, 0, 0);
	writeTable(4, ctrlWord(0, 0, JP_NEXT, CMD_LINE), 0, 32'h0000_7272,
		-20, 0, 70, 45, 0, 0, 0, 0);
	// Put local and system clip back for later tests
	writeTable(5, ctrlWord(0, 0, JP_NEXT, CMD_LOCAL), 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	writeTable(6, ctrlWord(0, 0, JP_NEXT, CMD_SYS_CLIP), 0, 0, 0, 0, 0, 0, 'h13F, 'hFF, 0, 0);
	writeTable(7, ctrlWord(1, 0, JP_NEXT, 4'h0), 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	locX = 10;
	locY = 5;
	sysX2 = 60;
	sysY2 = 40;
	ucX1 = 20;
	ucY1 = 10;
	ucX2 = 40;
	ucY2 = 30;
	plotLine(-20, 0, 70, 45, 32'h0400_6161);
	plotLine(-20, 0, 70, 45, 32'h0000_7272);
	runFrame();
	locX = 0;
	locY = 0;
	sysX2 = 'h13F;
	sysY2 = 'hFF;
	checkFrame("clip");
endtask

task automatic testJumps(input string name);
	logic [15:0] rd;
	clearAll();
	writeTable(0, ctrlWord(0, 0, JP_CALL, CMD_LINE), 20, 32'h0A0A, 5, 100, 25, 110, 0, 0, 0, 0);
	writeTable(5, ctrlWord(0, 0, JP_RETURN, CMD_LINE), 0, 32'h0B0B, 5, 120, 25, 125, 0, 0, 0, 0);
	writeTable(1, ctrlWord(0, 1, JP_JUMP, CMD_LINE), 12, 32'h0C0C, 5, 130, 25, 135, 0, 0, 0, 0);
	writeTable(2, ctrlWord(0, 0, JP_NEXT, CMD_LINE), 0, 32'h0D0D, 5, 140, 25, 145, 0, 0, 0, 0);
	writeTable(3, ctrlWord(0, 0, JP_NEXT, CMD_POLYLINE), 0, 32'h0E0E,
		40, 100, 70, 105, 65, 130, 42, 125);
	writeTable(4, ctrlWord(1, 0, JP_NEXT, 4'h0), 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	plotLine(5, 100, 25, 110, 32'h0A0A);
	plotLine(5, 120, 25, 125, 32'h0B0B);
	plotLine(40, 100, 70, 105, 32'h0E0E);
	plotLine(70, 105, 65, 130, 32'h0E0E);
	plotLine(65, 130, 42, 125, 32'h0E0E);
	plotLine(42, 125, 40, 100, 32'h0E0E);
	runFrame();
	checkFrame(name);
	busAccess(REG_COPR, 1'b0, 0, rd);
	checkVal({name, " COPR"}, 16, rd);
	busAccess(REG_LOPR, 1'b0, 0, rd);
	checkVal({name, " LOPR"}, 12, rd);
endtask

/* vdp1Tb.sv */
`timescale 1ns/10ps

module vdp1Tb import vdp1Pkg::*; ();

	localparam int NUM_TESTS = 5;
	localparam int CYCLES_PER_TEST = 2000;
	localparam int CLK_PERIOD = 20;
	localparam int FB_SIZE = 1 << FB_ADDR_W;

	logic                 CLK;
	logic                 RST_N;
	logic [15:0]          DI;
	logic [15:0]          DO;
	logic                 CS_N;
	logic                 AD_N;
	logic                 DTEN_N;
	logic [1:0]           WE_N;
	logic                 RDY_N;
	logic                 IRQ_N;
	logic [17:0]          VRAM_A;
	logic                 VRAM_RD;
	logic [31:0]          VRAM_Q;
	logic                 VRAM_ARDY;
	logic                 VRAM_DRDY;
	logic [FB_ADDR_W-1:0] FB_A;
	logic [15:0]          FB_D;
	logic                 FB_WE;

	// VRAM model, one 32-bit word per pair of 16-bit addresses
	logic [31:0] vram [0:1023];
	logic        vramPend;
	logic [17:0] vramAddrQ;
	int          vramLat;
	logic        stallOn;
	integer      seed;

	// Frame buffer seen by the DUT and the one the tests predict
	logic [15:0] fbData [0:FB_SIZE-1];
	logic [7:0]  fbCnt [0:FB_SIZE-1];
	logic [15:0] expData [0:FB_SIZE-1];
	logic [7:0]  expCnt [0:FB_SIZE-1];

	vdp1Top i_dut (
		.CLK(CLK), .RST_N(RST_N), .DI(DI), .DO(DO), .CS_N(CS_N), .AD_N(AD_N),
		.DTEN_N(DTEN_N), .WE_N(WE_N), .RDY_N(RDY_N), .IRQ_N(IRQ_N),
		.VRAM_A(VRAM_A), .VRAM_RD(VRAM_RD), .VRAM_Q(VRAM_Q), .VRAM_ARDY(VRAM_ARDY),
		.VRAM_DRDY(VRAM_DRDY), .FB_A(FB_A), .FB_D(FB_D), .FB_WE(FB_WE)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// Accept an address, wait a few cycles, then a one-cycle data strobe
	always @(posedge CLK) begin
		VRAM_ARDY <= stallOn ? (($random(seed) & 3) != 0) : 1'b1;
		if (vramPend) begin
			if (VRAM_DRDY) begin
				VRAM_DRDY <= 1'b0;
				vramPend <= 1'b0;
			end else if (vramLat == 0) begin
				VRAM_Q <= vram[vramAddrQ[10:1]];
				VRAM_DRDY <= 1'b1;
			end else begin
				vramLat <= vramLat - 1;
			end
		end else if (VRAM_RD && VRAM_ARDY) begin
			vramPend <= 1'b1;
			vramAddrQ <= VRAM_A;
			vramLat <= stallOn ? ($random(seed) & 3) : 1;
		end
	end

	always @(posedge CLK) begin
		if (FB_WE) begin
			fbData[FB_A] <= FB_D;
			fbCnt[FB_A] <= fbCnt[FB_A] + 8'd1;
		end
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic checkVal(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (expVal !== actVal) begin
			$display("Mismatch %s: expected %h actual %h", name, expVal, actVal);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	`include "vdp1TbTests.svh"

	initial begin
		seed = 57;
		stallOn = 1'b0;
		vramPend = 1'b0;
		vramLat = 0;
		VRAM_Q = '0;
		VRAM_ARDY = 1'b1;
		VRAM_DRDY = 1'b0;
		DI = '0;
		CS_N = 1'b1;
		AD_N = 1'b1;
		DTEN_N = 1'b1;
		WE_N = 2'b11;
		RST_N = 1'b0;
		repeat (10) @(posedge CLK);
		RST_N <= 1'b1;
		@(posedge CLK);
		testEndOfList();
		testLines();
		testClipLocal();
		testJumps("jumps");
		stallOn = 1'b1;
		testJumps("stalled jumps");
		$display("sim passed");
		$finish;
	end

	// Whole run budget plus the reset cycles
	initial begin
		#((NUM_TESTS * CYCLES_PER_TEST + 20) * CLK_PERIOD);
		failRun("Timeout: the tests did not finish in time");
	end

endmodule

/* vdp1Top.f */
+incdir+.
vdp1Pkg.sv
vdp1Regs.sv
vdp1CmdFetch.sv
vdp1CmdSeq.sv
vdp1LineDraw.sv
vdp1PixelOut.sv
vdp1Top.sv
vdp1Tb.sv

/* vdp1Top.sv */
`timescale 1ns/10ps

module vdp1Top import vdp1Pkg::*; (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic [15:0]          DI,
	output logic [15:0]          DO,
	input  logic                 CS_N,
	input  logic                 AD_N,
	input  logic                 DTEN_N,
	input  logic [1:0]           WE_N,
	output logic                 RDY_N,
	output logic                 IRQ_N,
	output logic [17:0]          VRAM_A,
	output logic                 VRAM_RD,
	input  logic [31:0]          VRAM_Q,
	input  logic                 VRAM_ARDY,
	input  logic                 VRAM_DRDY,
	output logic [FB_ADDR_W-1:0] FB_A,
	output logic [15:0]          FB_D,
	output logic                 FB_WE
);
	logic               frameStart;
	logic               listEnd;
	logic [15:0]        copr;
	logic               cmdRead;
	logic [17:0]        cmdAddr;
	logic               cmdDone;
	cmdWord_u           ctrlLink;
	logic [31:0]        pmodColr;
	cmdWord_u           vertA;
	cmdWord_u           vertB;
	cmdWord_u           vertC;
	cmdWord_u           vertD;
	logic               lineStart;
	cmdWord_u           lineA;
	cmdWord_u           lineB;
	logic               lineDone;
	logic [COORD_W-1:0] pixX;
	logic [COORD_W-1:0] pixY;
	logic               pixValid;
	logic [COORD_W-1:0] localX;
	logic [COORD_W-1:0] localY;
	logic [COORD_W-1:0] sysClipX2;
	logic [COORD_W-1:0] sysClipY2;
	logic [COORD_W-1:0] userClipX1;
	logic [COORD_W-1:0] userClipY1;
	logic [COORD_W-1:0] userClipX2;
	logic [COORD_W-1:0] userClipY2;

	vdp1Regs i_regs (
		.CLK(CLK), .RST_N(RST_N), .DI(DI), .DO(DO), .CS_N(CS_N), .AD_N(AD_N),
		.DTEN_N(DTEN_N), .WE_N(WE_N), .RDY_N(RDY_N), .IRQ_N(IRQ_N),
		.listEnd(listEnd), .copr(copr), .frameStart(frameStart)
	);

	vdp1CmdFetch i_fetch (
		.CLK(CLK), .RST_N(RST_N), .frameStart(frameStart), .cmdRead(cmdRead),
		.cmdAddr(cmdAddr), .VRAM_A(VRAM_A), .VRAM_RD(VRAM_RD), .VRAM_Q(VRAM_Q),
		.VRAM_ARDY(VRAM_ARDY), .VRAM_DRDY(VRAM_DRDY), .ctrlLink(ctrlLink),
		.pmodColr(pmodColr), .vertA(vertA), .vertB(vertB), .vertC(vertC),
		.vertD(vertD), .cmdDone(cmdDone)
	);

	vdp1CmdSeq i_seq (
		.CLK(CLK), .RST_N(RST_N), .frameStart(frameStart), .ctrlLink(ctrlLink),
		.pmodColr(pmodColr), .vertA(vertA), .vertB(vertB), .vertC(vertC), .vertD(vertD),
		.cmdDone(cmdDone), .cmdRead(cmdRead), .cmdAddr(cmdAddr), .lineStart(lineStart),
		.lineA(lineA), .lineB(lineB), .lineDone(lineDone), .listEnd(listEnd), .copr(copr),
		.localX(localX), .localY(localY), .sysClipX2(sysClipX2), .sysClipY2(sysClipY2),
		.userClipX1(userClipX1), .userClipY1(userClipY1),
		.userClipX2(userClipX2), .userClipY2(userClipY2)
	);

	vdp1LineDraw i_line (
		.CLK(CLK), .RST_N(RST_N), .lineStart(lineStart), .lineA(lineA), .lineB(lineB),
		.pixX(pixX), .pixY(pixY), .pixValid(pixValid), .lineDone(lineDone)
	);

	vdp1PixelOut i_pix (
		.pixX(pixX), .pixY(pixY), .pixValid(pixValid), .localX(localX), .localY(localY),
		.sysClipX2(sysClipX2), .sysClipY2(sysClipY2),
		.userClipX1(userClipX1), .userClipY1(userClipY1),
		.userClipX2(userClipX2), .userClipY2(userClipY2),
		.pmodColr(pmodColr), .FB_A(FB_A), .FB_D(FB_D), .FB_WE(FB_WE)
	);

endmodule
